// ==== flist.f ====
+incdir+common
common/switch_pkg.sv
cam/cam_table.sv
orchestrator/frame_decoder.sv
orchestrator/frame_forwarder.sv
logic/switch_core.sv
tests/switch_core_assert.sv
tests/switch_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal
TOP       ?= switch_core_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/switch_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "switch_consts.svh"

module switch_core_tb;

localparam int frame_total     = 36;
localparam int frame_max_len   = 72;
localparam int watchdog_cycles = frame_total * (`SW_SLOT_BYTES + 8) * 2;

logic                                   clock;
logic                                   rst_n;
switch_pkg::lane_t [`SW_PORTS-1:0]      port_receive_data;
switch_pkg::port_mask_t                 port_receive_valid;
switch_pkg::port_mask_t                 port_receive_ready;
switch_pkg::lane_t                      port_transmit_data;
switch_pkg::port_mask_t                 port_transmit_valid;

logic [7:0]             frame_bytes [frame_total][frame_max_len];
int                     frame_len   [frame_total];
int                     frame_port  [frame_total];
switch_pkg::mac_t       frame_dest  [frame_total];
switch_pkg::mac_t       frame_src   [frame_total];
int                     next_id = 0;
int                     round_ids [`SW_PORTS];

// Reference MAC table
logic                   ref_valid [`SW_CAM_DEPTH];
switch_pkg::mac_t       ref_mac   [`SW_CAM_DEPTH];
switch_pkg::port_idx_t  ref_port  [`SW_CAM_DEPTH];
int                     ref_pointer;

int                     expect_id [$];
switch_pkg::port_mask_t expect_mask [$];

int                     mismatches = 0;
int                     other_errors = 0;
int                     assertion_failures;
logic                   in_frame = 1'b0;
logic                   stray = 1'b0;
int                     cur_id;
int                     byte_idx;
switch_pkg::port_mask_t cur_mask;
switch_pkg::lane_t      expected_lane;

switch_core dut0 (
    .clock                  (clock),
    .rst_n                  (rst_n),
    .port_receive_data      (port_receive_data),
    .port_receive_valid     (port_receive_valid),
    .port_receive_ready     (port_receive_ready),
    .port_transmit_data     (port_transmit_data),
    .port_transmit_valid    (port_transmit_valid)
);

initial clock = 1'b0;
always #20 clock = ~clock;

//////////////////////////////////////////////////
// Frame construction and reference model

function automatic switch_pkg::mac_t mac_of(input int n);
    return {16'h0200, 32'(n)};
endfunction

function automatic int random_len();
    return `SW_MIN_FRAME + int'($urandom % (`SW_SLOT_BYTES - `SW_MIN_FRAME + 1));
endfunction

function automatic int build_frame(input int port, input switch_pkg::mac_t dest,
                                   input switch_pkg::mac_t src, input int len);
    int id;
    id = next_id;
    next_id++;
    frame_port[id] = port;
    frame_dest[id] = dest;
    frame_src[id]  = src;
    frame_len[id]  = len;
    for (int i = 0; i < frame_max_len; i++) begin
        if (i < 6)
            frame_bytes[id][i] = dest[47 - 8*i -: 8];
        else if (i < 12)
            frame_bytes[id][i] = src[95 - 8*i -: 8];
        else
            frame_bytes[id][i] = 8'($urandom);
    end
    return id;
endfunction

// Lookup uses the table before this frame's own learn step
task automatic model_accept(input int id);
    logic                   found;
    int                     entry;
    switch_pkg::port_idx_t  src_port;
    switch_pkg::port_idx_t  out_port;
    switch_pkg::port_mask_t mask;
    if (frame_len[id] < `SW_MIN_FRAME || frame_len[id] > `SW_SLOT_BYTES)
        return;
    src_port = switch_pkg::port_idx_t'(frame_port[id]);
    found    = 1'b0;
    out_port = '0;
    for (int i = 0; i < `SW_CAM_DEPTH; i++) begin
        if (!found && ref_valid[i] && ref_mac[i] == frame_dest[id]) begin
            found    = 1'b1;
            out_port = ref_port[i];
        end
    end
    mask = '0;
    if (frame_dest[id] == 48'hffff_ffff_ffff || !found) begin
        mask = '1;
        mask[src_port] = 1'b0;
    end else if (out_port != src_port) begin
        mask[out_port] = 1'b1;
    end
    entry = -1;
    for (int i = 0; i < `SW_CAM_DEPTH; i++)
        if (entry < 0 && ref_valid[i] && ref_mac[i] == frame_src[id])
            entry = i;
    for (int i = 0; i < `SW_CAM_DEPTH; i++)
        if (entry < 0 && !ref_valid[i])
            entry = i;
    if (entry < 0) begin
        entry       = ref_pointer;
        ref_pointer = (ref_pointer + 1) % `SW_CAM_DEPTH;
    end
    ref_valid[entry] = 1'b1;
    ref_mac[entry]   = frame_src[id];
    ref_port[entry]  = src_port;
    if (mask != '0) begin
        expect_id.push_back(id);
        expect_mask.push_back(mask);
    end
endtask

task automatic send_frame(input int id);
    int p;
    p = frame_port[id];
    for (int i = 0; i < frame_len[id]; i++) begin
        port_receive_data[p]  = {i == frame_len[id] - 1, frame_bytes[id][i]};
        port_receive_valid[p] = 1'b1;
        @(negedge clock);
        while (!port_receive_ready[p])
            @(negedge clock);
        @(posedge clock);
        #2;
    end
    port_receive_valid[p] = 1'b0;
    model_accept(id);
endtask

//////////////////////////////////////////////////
// Transmit monitor

always @(negedge clock) begin
    if (port_transmit_valid != '0) begin
        if (!in_frame && !stray) begin
            if (expect_id.size() == 0) begin
                $display("frame transmitted at %0t that no sent frame explains", $time);
                other_errors++;
                stray = 1'b1;
            end else begin
                cur_id   = expect_id.pop_front();
                cur_mask = expect_mask.pop_front();
                byte_idx = 0;
                in_frame = 1'b1;
            end
        end
        if (in_frame) begin
            expected_lane = {byte_idx == frame_len[cur_id] - 1, frame_bytes[cur_id][byte_idx]};
            assert (port_transmit_valid == cur_mask) else begin
                $display("mismatch at %0t: port_transmit_valid expected %b, got %b",
                         $time, cur_mask, port_transmit_valid);
                mismatches++;
            end
            assert (port_transmit_data == expected_lane) else begin
                $display("mismatch at %0t: port_transmit_data expected %h, got %h",
                         $time, expected_lane, port_transmit_data);
                mismatches++;
            end
            byte_idx++;
            if (byte_idx == frame_len[cur_id])
                in_frame = 1'b0;
        end
    end else begin
        if (in_frame) begin
            $display("frame %0d stopped after %0d of %0d bytes", cur_id, byte_idx,
                     frame_len[cur_id]);
            other_errors++;
        end
        in_frame = 1'b0;
        stray    = 1'b0;
    end
end

//////////////////////////////////////////////////
// Stimulus

initial begin
    void'($urandom(32'h1909_6cb7));
    rst_n              = 1'b0;
    port_receive_valid = '0;
    port_receive_data  = '0;
    ref_pointer        = 0;
    for (int i = 0; i < `SW_CAM_DEPTH; i++)
        ref_valid[i] = 1'b0;
    repeat (16) @(posedge clock);
    #2;
    rst_n = 1'b1;
    @(negedge clock);
    assert (port_receive_ready == '0) else begin
        $display("mismatch at %0t: port_receive_ready expected 0, got %b",
                 $time, port_receive_ready);
        mismatches++;
    end
    assert (port_transmit_valid == '0) else begin
        $display("mismatch at %0t: port_transmit_valid expected 0, got %b",
                 $time, port_transmit_valid);
        mismatches++;
    end
    @(posedge clock);
    #2;

    // Unknown destination, then learned unicast
    send_frame(build_frame(0, mac_of(100), mac_of(0), random_len()));
    send_frame(build_frame(1, mac_of(0), mac_of(1), random_len()));
    send_frame(build_frame(2, mac_of(1), mac_of(2), random_len()));

    // Broadcast address learned as a source still floods
    send_frame(build_frame(1, mac_of(0), 48'hffff_ffff_ffff, random_len()));
    send_frame(build_frame(3, 48'hffff_ffff_ffff, mac_of(3), random_len()));

    // Same-port, runt and over-long drops
    send_frame(build_frame(0, mac_of(0), mac_of(5), random_len()));
    send_frame(build_frame(2, mac_of(3), mac_of(2), `SW_MIN_FRAME - 4));
    send_frame(build_frame(3, mac_of(2), mac_of(3), `SW_SLOT_BYTES + 6));
    send_frame(build_frame(2, mac_of(3), mac_of(2), random_len()));

    // Station move
    send_frame(build_frame(3, mac_of(2), mac_of(1), random_len()));
    send_frame(build_frame(0, mac_of(1), mac_of(0), random_len()));

    // Table overflow evicts the oldest entries
    for (int i = 0; i < 12; i++)
        send_frame(build_frame(1, mac_of(3), mac_of(20 + i), random_len()));
    send_frame(build_frame(2, mac_of(0), mac_of(40), random_len()));

    // All ports at once
    for (int r = 0; r < 3; r++) begin
        for (int p = 0; p < `SW_PORTS; p++) begin
            round_ids[p] = build_frame(p,
                r == 0 ? (p == 0 ? 48'hffff_ffff_ffff : mac_of(200 + p))
                       : mac_of(50 + 4*(r - 1) + (p + 1) % `SW_PORTS),
                mac_of(50 + 4*r + p),
                (r == 0 && p == 0) ? `SW_SLOT_BYTES : random_len());
        end
        fork
            send_frame(round_ids[0]);
            send_frame(round_ids[1]);
            send_frame(round_ids[2]);
            send_frame(round_ids[3]);
        join
    end

    while (expect_id.size() != 0 || in_frame)
        @(posedge clock);
    repeat (`SW_SLOT_BYTES + 8) @(posedge clock);

    assertion_failures = dut0.protocol_checks.failures;
    $display("closing: %0d mismatches, %0d other errors, %0d assertion failures",
             mismatches, other_errors, assertion_failures);
    if (mismatches + other_errors + assertion_failures == 0) begin
        $display("Test OK");
    end else begin
        $display("Test FAILED");
    end
    $finish;
end

initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("timeout after %0d cycles: %0d expected frames never arrived, %0d mismatches",
             watchdog_cycles, expect_id.size(), mismatches);
    $display("Test FAILED");
    $finish;
end

endmodule

`default_nettype wire

// ==== tests/switch_core_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "switch_consts.svh"

module switch_core_assert (
    input wire                                      clock,
    input wire                                      rst_n,
    input wire switch_pkg::lane_t [`SW_PORTS-1:0]   port_receive_data,
    input wire switch_pkg::port_mask_t              port_receive_valid,
    input wire switch_pkg::port_mask_t              port_receive_ready,
    input wire switch_pkg::port_mask_t              port_transmit_valid,
    input wire                                      lookup_valid,
    input wire                                      match_valid,
    input wire                                      slot_valid,
    input wire                                      slot_release,
    input wire switch_pkg::slot_idx_t               slot_index,
    input wire switch_pkg::slot_idx_t               slot_read_index,
    input wire switch_pkg::port_idx_t               source_port
);

int                     failures = 0;
switch_pkg::port_idx_t  slot_source [2];
switch_pkg::slot_idx_t  tx_slot_d1;
switch_pkg::slot_idx_t  tx_slot_d2;
logic [1:0]             slots_used;
logic                   both_full;
switch_pkg::port_mask_t ready_d1;
logic                   ready_hold;
logic                   last_taken;

// A slot counts as full from its lookup cycle until its release
always_ff @(posedge clock) begin
    if (!rst_n) begin
        slots_used <= '0;
    end else if (lookup_valid && !slot_release) begin
        slots_used <= slots_used + 1'b1;
    end else if (slot_release && !lookup_valid) begin
        slots_used <= slots_used - 1'b1;
    end
end

assign both_full = (slots_used == 2'd2) || (slots_used == 2'd1 && lookup_valid);

// Transmit lane trails the slot read by two cycles
always_ff @(posedge clock) begin
    if (slot_valid && match_valid)
        slot_source[slot_index] <= source_port;
    tx_slot_d1 <= slot_read_index;
    tx_slot_d2 <= tx_slot_d1;
end

// Marker byte accepted on the selected port
always_comb begin
    last_taken = 1'b0;
    for (int i = 0; i < `SW_PORTS; i++) begin
        if (port_receive_ready[i] && port_receive_valid[i] && port_receive_data[i][8])
            last_taken = 1'b1;
    end
end

always_ff @(posedge clock) begin
    ready_d1   <= port_receive_ready;
    ready_hold <= (port_receive_ready != '0) && !last_taken;
end

//////////////////////////////////////////////////
// Protocol properties

// Selected port keeps ready until its last byte has been taken
ready_onehot: assert property (@(posedge clock) disable iff (!rst_n)
    $onehot0(port_receive_ready) && (!ready_hold || port_receive_ready == ready_d1))
    else begin
        $error("port_receive_ready not one-hot or moved before the last byte");
        failures++;
    end

no_echo: assert property (@(posedge clock) disable iff (!rst_n)
    (port_transmit_valid != '0) |-> !port_transmit_valid[slot_source[tx_slot_d2]])
    else begin
        $error("frame transmitted back to its source port");
        failures++;
    end

full_blocks_receive: assert property (@(posedge clock) disable iff (!rst_n)
    both_full |-> (port_receive_ready == '0))
    else begin
        $error("port_receive_ready high while both slots are full");
        failures++;
    end

reset_outputs: assert property (@(posedge clock)
    !rst_n |=> (port_receive_ready == '0 && port_transmit_valid == '0
                && !lookup_valid && !match_valid))
    else begin
        $error("outputs not low after reset");
        failures++;
    end

endmodule

bind switch_core switch_core_assert protocol_checks (
    .clock                  (clock),
    .rst_n                  (rst_n),
    .port_receive_data      (port_receive_data),
    .port_receive_valid     (port_receive_valid),
    .port_receive_ready     (port_receive_ready),
    .port_transmit_valid    (port_transmit_valid),
    .lookup_valid           (lookup_valid),
    .match_valid            (match_valid),
    .slot_valid             (slot_valid),
    .slot_release           (slot_release),
    .slot_index             (slot_index),
    .slot_read_index        (slot_read_index),
    .source_port            (source_port)
);

`default_nettype wire

// ==== logic/switch_core.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "switch_consts.svh"

module switch_core (
    input  wire                                         clock,
    input  wire                                         rst_n,
    input  wire switch_pkg::lane_t [`SW_PORTS-1:0]      port_receive_data,
    input  wire switch_pkg::port_mask_t                 port_receive_valid,
    output wire switch_pkg::port_mask_t                 port_receive_ready,
    output wire switch_pkg::lane_t                      port_transmit_data,
    output wire switch_pkg::port_mask_t                 port_transmit_valid
);

wire                            lookup_valid;
wire    switch_pkg::mac_t       source_mac;
wire    switch_pkg::mac_t       dest_mac;
wire    switch_pkg::port_idx_t  source_port;
wire                            slot_valid;
wire    switch_pkg::slot_idx_t  slot_index;
wire    switch_pkg::slot_addr_t slot_length;
wire    switch_pkg::lane_t      slot_read_data;
wire    switch_pkg::slot_addr_t slot_read_address;
wire    switch_pkg::slot_idx_t  slot_read_index;
wire                            slot_release;
wire                            match_valid;
wire                            hit;
wire    switch_pkg::port_idx_t  match_port;

frame_decoder frame_decoder (
    .clock              (clock),
    .rst_n              (rst_n),
    .port_receive_data  (port_receive_data),
    .port_receive_valid (port_receive_valid),
    .slot_read_address  (slot_read_address),
    .slot_read_index    (slot_read_index),
    .slot_release       (slot_release),
    .port_receive_ready (port_receive_ready),
    .lookup_valid       (lookup_valid),
    .source_mac         (source_mac),
    .dest_mac           (dest_mac),
    .source_port        (source_port),
    .slot_valid         (slot_valid),
    .slot_index         (slot_index),
    .slot_length        (slot_length),
    .slot_read_data     (slot_read_data)
);

cam_table cam_table (
    .clock          (clock),
    .rst_n          (rst_n),
    .lookup_valid   (lookup_valid),
    .source_mac     (source_mac),
    .dest_mac       (dest_mac),
    .source_port    (source_port),
    .match_valid    (match_valid),
    .hit            (hit),
    .match_port     (match_port)
);

frame_forwarder frame_forwarder (
    .clock                  (clock),
    .rst_n                  (rst_n),
    .slot_valid             (slot_valid),
    .slot_index             (slot_index),
    .slot_length            (slot_length),
    .dest_mac               (dest_mac),
    .match_valid            (match_valid),
    .hit                    (hit),
    .match_port             (match_port),
    .source_port            (source_port),
    .slot_read_data         (slot_read_data),
    .slot_read_address      (slot_read_address),
    .slot_read_index        (slot_read_index),
    .slot_release           (slot_release),
    .port_transmit_data     (port_transmit_data),
    .port_transmit_valid    (port_transmit_valid)
);

endmodule

`default_nettype wire

// ==== orchestrator/frame_forwarder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "switch_consts.svh"

module frame_forwarder (
    input  wire                             clock,
    input  wire                             rst_n,
    input  wire                             slot_valid,
    input  wire switch_pkg::slot_idx_t      slot_index,
    input  wire switch_pkg::slot_addr_t     slot_length,
    input  wire switch_pkg::mac_t           dest_mac,
    input  wire                             match_valid,
    input  wire                             hit,
    input  wire switch_pkg::port_idx_t      match_port,
    input  wire switch_pkg::port_idx_t      source_port,
    input  wire switch_pkg::lane_t          slot_read_data,
    output switch_pkg::slot_addr_t          slot_read_address,
    output switch_pkg::slot_idx_t           slot_read_index,
    output logic                            slot_release,
    output switch_pkg::lane_t               port_transmit_data,
    output switch_pkg::port_mask_t          port_transmit_valid
);

switch_pkg::forwarder_state_t   state;
switch_pkg::port_mask_t         flood_mask;
switch_pkg::port_mask_t         target_mask;
switch_pkg::port_mask_t         frame_mask;
switch_pkg::port_mask_t         pending_mask;
switch_pkg::port_mask_t         start_mask;
switch_pkg::slot_idx_t          pending_index;
switch_pkg::slot_idx_t          start_index;
switch_pkg::slot_addr_t         pending_length;
switch_pkg::slot_addr_t         start_length;
switch_pkg::slot_addr_t         last_address;
logic                           take;
logic                           pending_valid;
logic                           start_from_pending;
logic                           start_from_input;
logic                           start;
logic                           read_valid;

//////////////////////////////////////////////////
// Forwarding decision

assign flood_mask = ~(switch_pkg::port_mask_t'(1) << source_port);

always_comb begin
    if (dest_mac == '1 || !hit)
        target_mask = flood_mask;
    else if (match_port != source_port)
        target_mask = switch_pkg::port_mask_t'(1) << match_port;
    else
        target_mask = '0;
end

assign take = slot_valid && match_valid;

// Second slot waits here while the first one is streaming
assign start_from_pending = (state == switch_pkg::fwd_idle) && pending_valid;
assign start_from_input   = (state == switch_pkg::fwd_idle) && !pending_valid && take;
assign start              = start_from_pending || start_from_input;

assign start_index  = pending_valid ? pending_index  : slot_index;
assign start_length = pending_valid ? pending_length : slot_length;
assign start_mask   = pending_valid ? pending_mask   : target_mask;

//////////////////////////////////////////////////
// Stream control

always_ff @(posedge clock) begin
    if (!rst_n) begin
        state               <= switch_pkg::fwd_idle;
        pending_valid       <= 1'b0;
        slot_release        <= 1'b0;
        read_valid          <= 1'b0;
        port_transmit_valid <= '0;
    end else begin
        slot_release        <= 1'b0;
        read_valid          <= (state == switch_pkg::fwd_send);
        port_transmit_valid <= read_valid ? frame_mask : '0;
        if (take && !start_from_input)
            pending_valid <= 1'b1;
        else if (start_from_pending)
            pending_valid <= 1'b0;
        case (state)
            switch_pkg::fwd_idle: begin
                if (start) begin
                    // Empty target set means the frame is dropped
                    if (start_mask == '0)
                        slot_release <= 1'b1;
                    else
                        state <= switch_pkg::fwd_send;
                end
            end
            switch_pkg::fwd_send: begin
                if (slot_read_address == last_address) begin
                    state        <= switch_pkg::fwd_idle;
                    slot_release <= 1'b1;
                end
            end
            default: state <= switch_pkg::fwd_idle;
        endcase
    end
end

always_ff @(posedge clock) begin
    if (take && !start_from_input) begin
        pending_index  <= slot_index;
        pending_length <= slot_length;
        pending_mask   <= target_mask;
    end
    if (start) begin
        slot_read_index   <= start_index;
        last_address      <= start_length;
        frame_mask        <= start_mask;
        slot_read_address <= '0;
    end else if (state == switch_pkg::fwd_send) begin
        slot_read_address <= slot_read_address + 1'b1;
    end
    port_transmit_data <= slot_read_data;
end

endmodule

`default_nettype wire

// ==== orchestrator/frame_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "switch_consts.svh"

module frame_decoder (
    input  wire                                         clock,
    input  wire                                         rst_n,
    input  wire switch_pkg::lane_t [`SW_PORTS-1:0]      port_receive_data,
    input  wire switch_pkg::port_mask_t                 port_receive_valid,
    input  wire switch_pkg::slot_addr_t                 slot_read_address,
    input  wire switch_pkg::slot_idx_t                  slot_read_index,
    input  wire                                         slot_release,
    output switch_pkg::port_mask_t                      port_receive_ready,
    output logic                                        lookup_valid,
    output switch_pkg::mac_t                            source_mac,
    output switch_pkg::mac_t                            dest_mac,
    output switch_pkg::port_idx_t                       source_port,
    output logic                                        slot_valid,
    output switch_pkg::slot_idx_t                       slot_index,
    output switch_pkg::slot_addr_t                      slot_length,
    output switch_pkg::lane_t                           slot_read_data
);

switch_pkg::decoder_state_t state;
logic [1:0]                 slot_full;
switch_pkg::lane_t          slot_mem [2*`SW_SLOT_BYTES];
switch_pkg::slot_addr_t     byte_count;
switch_pkg::port_idx_t      next_port;
switch_pkg::port_idx_t      candidate;
logic                       request_found;
logic                       slot_free;
logic                       grant;
switch_pkg::slot_idx_t      free_slot;
switch_pkg::lane_t          rx_lane;
logic                       rx_active;
logic                       rx_fire;

//////////////////////////////////////////////////
// Port arbitration

// Search starts one past the previous winner
always_comb begin
    next_port = source_port;
    request_found = 1'b0;
    for (int i = 1; i <= `SW_PORTS; i++) begin
        candidate = switch_pkg::port_idx_t'(source_port + i);
        if (!request_found && port_receive_valid[candidate]) begin
            request_found = 1'b1;
            next_port = candidate;
        end
    end
end

assign slot_free = ~&slot_full;
assign free_slot = slot_full[0];
assign grant     = (state == switch_pkg::dec_idle) && slot_free && request_found;

assign rx_active    = (state == switch_pkg::dec_receive) || (state == switch_pkg::dec_discard);
assign rx_lane      = port_receive_data[source_port];
assign rx_fire      = rx_active && port_receive_valid[source_port];
assign lookup_valid = (state == switch_pkg::dec_lookup);

always_comb begin
    port_receive_ready = '0;
    if (rx_active)
        port_receive_ready[source_port] = 1'b1;
end

//////////////////////////////////////////////////
// Frame FSM

always_ff @(posedge clock) begin
    if (!rst_n) begin
        state       <= switch_pkg::dec_idle;
        slot_full   <= '0;
        slot_valid  <= 1'b0;
        source_port <= '0;
    end else begin
        slot_valid <= 1'b0;
        if (slot_release)
            slot_full[slot_read_index] <= 1'b0;
        case (state)
            switch_pkg::dec_idle: begin
                if (grant) begin
                    source_port <= next_port;
                    state       <= switch_pkg::dec_receive;
                end
            end
            switch_pkg::dec_receive: begin
                if (rx_fire) begin
                    if (rx_lane[8]) begin
                        // Runt frames never reach the table
                        if (byte_count < switch_pkg::slot_addr_t'(`SW_MIN_FRAME - 1)) begin
                            state <= switch_pkg::dec_idle;
                        end else begin
                            state <= switch_pkg::dec_lookup;
                            slot_full[slot_index] <= 1'b1;
                        end
                    end else if (byte_count == switch_pkg::slot_addr_t'(`SW_SLOT_BYTES - 1)) begin
                        state <= switch_pkg::dec_discard;
                    end
                end
            end
            switch_pkg::dec_discard: begin
                if (rx_fire && rx_lane[8])
                    state <= switch_pkg::dec_idle;
            end
            switch_pkg::dec_lookup: begin
                state      <= switch_pkg::dec_idle;
                slot_valid <= 1'b1;
            end
            default: state <= switch_pkg::dec_idle;
        endcase
    end
end

//////////////////////////////////////////////////
// Header capture and slot store

always_ff @(posedge clock) begin
    if (grant) begin
        byte_count <= '0;
        slot_index <= free_slot;
    end
    if (rx_fire && state == switch_pkg::dec_receive) begin
        if (byte_count < 6'd6)
            dest_mac <= {dest_mac[39:0], rx_lane[7:0]};
        else if (byte_count < 6'd12)
            source_mac <= {source_mac[39:0], rx_lane[7:0]};
        slot_length <= byte_count;
        byte_count  <= byte_count + 1'b1;
    end
end

always_ff @(posedge clock) begin
    if (rx_fire && state == switch_pkg::dec_receive)
        slot_mem[{slot_index, byte_count}] <= rx_lane;
    slot_read_data <= slot_mem[{slot_read_index, slot_read_address}];
end

endmodule

`default_nettype wire

// ==== cam/cam_table.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "switch_consts.svh"

module cam_table (
    input  wire                             clock,
    input  wire                             rst_n,
    input  wire                             lookup_valid,
    input  wire switch_pkg::mac_t           source_mac,
    input  wire switch_pkg::mac_t           dest_mac,
    input  wire switch_pkg::port_idx_t      source_port,
    output logic                            match_valid,
    output logic                            hit,
    output switch_pkg::port_idx_t           match_port
);

logic [`SW_CAM_DEPTH-1:0]   entry_valid;
switch_pkg::mac_t           entry_mac  [`SW_CAM_DEPTH];
switch_pkg::port_idx_t      entry_port [`SW_CAM_DEPTH];
switch_pkg::cam_idx_t       replace_pointer;
logic                       dest_found;
switch_pkg::port_idx_t      dest_port;
logic                       source_found;
switch_pkg::cam_idx_t       source_index;
logic                       free_found;
switch_pkg::cam_idx_t       free_index;
switch_pkg::cam_idx_t       learn_index;

//////////////////////////////////////////////////
// Parallel compare

always_comb begin
    dest_found   = 1'b0;
    dest_port    = '0;
    source_found = 1'b0;
    source_index = '0;
    free_found   = 1'b0;
    free_index   = '0;
    for (int i = 0; i < `SW_CAM_DEPTH; i++) begin
        if (!dest_found && entry_valid[i] && entry_mac[i] == dest_mac) begin
            dest_found = 1'b1;
            dest_port  = entry_port[i];
        end
        if (!source_found && entry_valid[i] && entry_mac[i] == source_mac) begin
            source_found = 1'b1;
            source_index = switch_pkg::cam_idx_t'(i);
        end
        if (!free_found && !entry_valid[i]) begin
            free_found = 1'b1;
            free_index = switch_pkg::cam_idx_t'(i);
        end
    end
end

// Known MAC first, then an empty entry, then the oldest slot
assign learn_index = source_found ? source_index :
                     free_found   ? free_index   : replace_pointer;

//////////////////////////////////////////////////
// Learn and result registers

always_ff @(posedge clock) begin
    if (!rst_n) begin
        entry_valid     <= '0;
        replace_pointer <= '0;
        match_valid     <= 1'b0;
    end else begin
        match_valid <= lookup_valid;
        if (lookup_valid) begin
            entry_valid[learn_index] <= 1'b1;
            if (!source_found && !free_found)
                replace_pointer <= replace_pointer + 1'b1;
        end
    end
end

always_ff @(posedge clock) begin
    if (lookup_valid) begin
        entry_mac[learn_index]  <= source_mac;
        entry_port[learn_index] <= source_port;
        hit                     <= dest_found;
        match_port              <= dest_port;
    end
end

endmodule

`default_nettype wire

// ==== common/switch_pkg.sv ====
`default_nettype none

`include "switch_consts.svh"

package switch_pkg;

    // Byte lane whose bit 8 flags the last byte of a frame
    typedef logic [8:0]                             lane_t;
    typedef logic [47:0]                            mac_t;
    typedef logic [$clog2(`SW_PORTS)-1:0]           port_idx_t;
    typedef logic [`SW_PORTS-1:0]                   port_mask_t;
    typedef logic [$clog2(`SW_CAM_DEPTH)-1:0]       cam_idx_t;
    typedef logic                                   slot_idx_t;
    typedef logic [$clog2(`SW_SLOT_BYTES)-1:0]      slot_addr_t;

    typedef enum logic [1:0] {
        dec_idle,
        dec_receive,
        dec_discard,
        dec_lookup
    } decoder_state_t;

    typedef enum logic {
        fwd_idle,
        fwd_send
    } forwarder_state_t;

endpackage

`default_nettype wire

// ==== common/switch_consts.svh ====
`ifndef SWITCH_CONSTS_SVH
`define SWITCH_CONSTS_SVH

// Port count of the forwarding core
`define SW_PORTS        4

// Learned MAC entries
`define SW_CAM_DEPTH    16

// Bytes held by one frame slot
`define SW_SLOT_BYTES   64

// Two MAC addresses plus ethertype
`define SW_MIN_FRAME    14

`endif
